//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - decode_if.sv
  - lsu_if.sv
  - rv_decoder.sv
  - rv_regfile.sv
  - rv_alu.sv
  - rv_lsu.sv
  - rv_control.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv

//--- decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if import rv_pkg::*; ();

	logic [reg_aw-1:0] rd; // zero when nothing is written
	logic [reg_aw-1:0] rs1; // combinational
	logic [reg_aw-1:0] rs2;
	logic [xlen-1:0] imm;
	inst_class_t cls;
	alu_op_t alu_op;
	logic use_imm;
	mem_size_t size;
	logic unsigned_ld;

	modport decoder (output rd, rs1, rs2, imm, cls, alu_op, use_imm, size, unsigned_ld);
	modport consumer (input imm, cls, alu_op, use_imm, size, unsigned_ld);
	modport regfile (input rd, rs1, rs2);

endinterface

`default_nettype wire

//--- lsu_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lsu_if import rv_pkg::*; ();

	logic start; // one-cycle pulse, lsu idle
	logic fetch; // whole word, no extension
	logic store;
	mem_size_t size;
	logic unsigned_ld;
	logic [xlen-1:0] addr;
	logic [xlen-1:0] wdata;
	logic done; // one-cycle pulse
	logic [xlen-1:0] rdata; // valid with done

	modport master (output start, fetch, store, size, unsigned_ld, addr, wdata,
		input done, rdata);
	modport lsu (input start, fetch, store, size, unsigned_ld, addr, wdata,
		output done, rdata);

endinterface

`default_nettype wire

//--- rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
	input wire logic clk,
	input wire logic rstn,
	decode_if.consumer dec,
	input wire logic [xlen-1:0] src1,
	input wire logic [xlen-1:0] src2,
	output logic [xlen-1:0] result
);

	logic [xlen-1:0] opb;
	logic [4:0] shamt;
	logic [xlen-1:0] res_n;

	assign opb = dec.use_imm ? dec.imm : src2;
	assign shamt = opb[4:0];

	always_comb begin
		case (dec.alu_op)
			alu_add: res_n = src1 + opb;
			alu_sub: res_n = src1 - opb;
			alu_sll: res_n = src1 << shamt;
			alu_slt: res_n = xlen'($signed(src1) < $signed(opb));
			alu_sltu: res_n = xlen'(src1 < opb);
			alu_xor: res_n = src1 ^ opb;
			alu_srl: res_n = src1 >> shamt;
			alu_sra: res_n = $signed(src1) >>> shamt;
			alu_or: res_n = src1 | opb;
			alu_and: res_n = src1 & opb;
			alu_eq: res_n = xlen'(src1 == opb);
			alu_ne: res_n = xlen'(src1 != opb);
			alu_lt: res_n = xlen'($signed(src1) < $signed(opb));
			alu_ge: res_n = xlen'($signed(src1) >= $signed(opb));
			alu_ltu: res_n = xlen'(src1 < opb);
			alu_geu: res_n = xlen'(src1 >= opb);
			default: res_n = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn)
			result <= '0;
		else if (dec.cls == cls_store)
			result <= src2; // store data for the memory phase
		else
			result <= res_n;
	end

endmodule

`default_nettype wire

//--- rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control import rv_pkg::*; (
	input wire logic clk,
	input wire logic rstn,
	decode_if.consumer dec,
	lsu_if.master mem,
	input wire logic [xlen-1:0] rs1_data,
	input wire logic [xlen-1:0] alu_result,
	output logic [xlen-1:0] instr,
	output logic rf_we,
	output logic [xlen-1:0] rf_wdata
);

	typedef enum logic [2:0] {ph_fetch, ph_decode, ph_exec, ph_mem, ph_wb} phase_t;

	phase_t phase;
	logic pending; // lsu request outstanding
	logic issue;
	logic is_mem;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_next;
	logic [xlen-1:0] ea;
	logic [xlen-1:0] ld_data;

	assign ea = rs1_data + dec.imm;
	assign is_mem = dec.cls inside {cls_load, cls_store};
	assign issue = !pending && (phase == ph_fetch || (phase == ph_mem && is_mem));

	always_comb begin
		case (dec.cls)
			cls_jal: pc_next = pc + dec.imm;
			cls_jalr: pc_next = {ea[xlen-1:1], 1'b0};
			cls_branch: pc_next = (alu_result != '0) ? pc + dec.imm : pc + pc_step;
			default: pc_next = pc + pc_step;
		endcase
	end

	always_comb begin
		case (dec.cls)
			cls_lui: rf_wdata = dec.imm;
			cls_auipc: rf_wdata = pc + dec.imm;
			cls_jal, cls_jalr: rf_wdata = pc + pc_step; // link
			cls_load: rf_wdata = ld_data;
			default: rf_wdata = alu_result;
		endcase
	end

	assign rf_we = phase == ph_wb &&
		dec.cls inside {cls_lui, cls_auipc, cls_jal, cls_jalr, cls_load, cls_alu};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			phase <= ph_fetch;
			pending <= 1'b0;
			pc <= reset_pc;
			instr <= '0;
			mem.start <= 1'b0;
		end else begin
			mem.start <= issue;
			if (issue)
				pending <= 1'b1;
			case (phase)
				ph_fetch: if (mem.done) begin
					instr <= mem.rdata;
					pending <= 1'b0;
					phase <= ph_decode;
				end
				ph_decode: phase <= ph_exec;
				ph_exec: phase <= ph_mem;
				ph_mem: if (!is_mem || mem.done) begin
					pending <= 1'b0;
					phase <= ph_wb;
				end
				default: begin
					pc <= pc_next;
					phase <= ph_fetch;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			mem.fetch <= phase == ph_fetch;
			mem.store <= phase == ph_mem && dec.cls == cls_store;
			mem.size <= dec.size;
			mem.unsigned_ld <= dec.unsigned_ld;
			mem.addr <= (phase == ph_fetch) ? pc : ea;
			mem.wdata <= alu_result; // rs2 passed through the alu
		end
		if (phase == ph_mem && mem.done)
			ld_data <= mem.rdata;
	end

	// one write per instruction, right after the memory phase
	a_wb_only: assert property (@(posedge clk) disable iff (!rstn)
		rf_we |-> $past(phase) == ph_mem && !$past(rf_we));

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
	input wire logic clk,
	input wire logic rstn,
	output wire logic [xlen-1:0] araddr,
	output wire logic arvalid,
	input wire logic arready,
	input wire logic [xlen-1:0] rdata,
	input wire logic rvalid,
	output wire logic rready,
	output wire logic [xlen-1:0] awaddr,
	output wire logic awvalid,
	input wire logic awready,
	output wire logic [xlen-1:0] wdata,
	output wire logic [3:0] wstrb,
	output wire logic wvalid,
	input wire logic wready,
	input wire logic bvalid,
	output wire logic bready
);

	logic [xlen-1:0] instr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] alu_result;
	logic rf_we;
	logic [xlen-1:0] rf_wdata;

	decode_if dec_bus();
	lsu_if mem_bus();

	rv_decoder i_decoder (
		.clk(clk), .rstn(rstn), .instr(instr), .dec(dec_bus)
	);

	rv_regfile i_regfile (
		.clk(clk), .rstn(rstn), .dec(dec_bus),
		.we(rf_we), .wdata(rf_wdata),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	rv_alu i_alu (
		.clk(clk), .rstn(rstn), .dec(dec_bus),
		.src1(rs1_data), .src2(rs2_data), .result(alu_result)
	);

	rv_control i_control (
		.clk(clk), .rstn(rstn), .dec(dec_bus), .mem(mem_bus),
		.rs1_data(rs1_data), .alu_result(alu_result),
		.instr(instr), .rf_we(rf_we), .rf_wdata(rf_wdata)
	);

	rv_lsu i_lsu (
		.clk(clk), .rstn(rstn), .req(mem_bus),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready)
	);

endmodule

`default_nettype wire

//--- rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
	input wire logic clk,
	input wire logic rstn,
	input wire logic [xlen-1:0] instr,
	decode_if.decoder dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic alt;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	inst_class_t cls_n;
	alu_op_t alu_n;
	logic [xlen-1:0] imm_n;
	logic use_imm_n;
	mem_size_t size_n;
	logic uns_n;

	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt_op);
		case (f3)
			3'b000: return alt_op ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt_op ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign alt = funct7 == funct7_alt;

	assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
	assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'd0};
	assign imm_j = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// regfile reads these in the decode cycle
	assign dec.rs1 = instr[19:15];
	assign dec.rs2 = instr[24:20];

	always_comb begin
		cls_n = cls_none;
		alu_n = alu_add;
		imm_n = imm_i;
		use_imm_n = 1'b0;
		size_n = mem_size_t'(funct3[1:0]);
		uns_n = funct3[2];
		case (opcode)
			opc_lui: begin
				cls_n = cls_lui;
				imm_n = imm_u;
			end
			opc_auipc: begin
				cls_n = cls_auipc;
				imm_n = imm_u;
			end
			opc_jal: begin
				cls_n = cls_jal;
				imm_n = imm_j;
			end
			opc_jalr: cls_n = cls_jalr;
			opc_branch: begin
				cls_n = (funct3[2:1] == 2'b01) ? cls_none : cls_branch;
				imm_n = imm_b;
				case (funct3)
					3'b000: alu_n = alu_eq;
					3'b001: alu_n = alu_ne;
					3'b100: alu_n = alu_lt;
					3'b101: alu_n = alu_ge;
					3'b110: alu_n = alu_ltu;
					default: alu_n = alu_geu;
				endcase
			end
			opc_load: begin
				if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101})
					cls_n = cls_load;
			end
			opc_store: begin
				if (funct3 inside {3'b000, 3'b001, 3'b010})
					cls_n = cls_store;
				imm_n = imm_s;
			end
			opc_op_imm: begin
				use_imm_n = 1'b1;
				alu_n = arith_op(funct3, funct3 == 3'b101 && alt); // addi never subtracts
				if (funct3 == 3'b001)
					cls_n = (funct7 == 7'd0) ? cls_alu : cls_none;
				else if (funct3 == 3'b101)
					cls_n = (funct7 == 7'd0 || alt) ? cls_alu : cls_none;
				else
					cls_n = cls_alu;
			end
			opc_op: begin
				alu_n = arith_op(funct3, alt);
				if (funct7 == 7'd0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101)))
					cls_n = cls_alu;
			end
			default: cls_n = cls_none; // retires as a nop
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec.cls <= cls_none;
			dec.rd <= '0;
		end else begin
			dec.cls <= cls_n;
			dec.rd <= (cls_n inside {cls_none, cls_branch, cls_store}) ? '0 : instr[11:7];
		end
	end

	always_ff @(posedge clk) begin
		dec.imm <= imm_n;
		dec.alu_op <= alu_n;
		dec.use_imm <= use_imm_n;
		dec.size <= size_n;
		dec.unsigned_ld <= uns_n;
	end

endmodule

`default_nettype wire

//--- rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu import rv_pkg::*; (
	input wire logic clk,
	input wire logic rstn,
	lsu_if.lsu req,
	output logic [xlen-1:0] araddr,
	output logic arvalid,
	input wire logic arready,
	input wire logic [xlen-1:0] rdata,
	input wire logic rvalid,
	output logic rready,
	output logic [xlen-1:0] awaddr,
	output logic awvalid,
	input wire logic awready,
	output logic [xlen-1:0] wdata,
	output logic [3:0] wstrb,
	output logic wvalid,
	input wire logic wready,
	input wire logic bvalid,
	output logic bready
);

	typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} lsu_state_t;

	lsu_state_t state;
	logic op_store;
	logic op_fetch;
	logic op_uns;
	mem_size_t op_size;
	logic [1:0] lane;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;
	logic [xlen-1:0] ld_val;
	logic [3:0] wr_strb;
	logic [xlen-1:0] wr_data;

	assign ld_byte = rdata[{lane, 3'b000} +: 8];
	assign ld_half = lane[1] ? rdata[31:16] : rdata[15:0];

	always_comb begin
		if (op_fetch || op_size == sz_word)
			ld_val = rdata;
		else if (op_size == sz_half)
			ld_val = {{(xlen-16){~op_uns & ld_half[15]}}, ld_half};
		else
			ld_val = {{(xlen-8){~op_uns & ld_byte[7]}}, ld_byte};
	end

	// store data is copied into every lane, wstrb picks
	always_comb begin
		case (req.size)
			sz_byte: begin
				wr_strb = 4'b0001 << req.addr[1:0];
				wr_data = {4{req.wdata[7:0]}};
			end
			sz_half: begin
				wr_strb = req.addr[1] ? 4'b1100 : 4'b0011;
				wr_data = {2{req.wdata[15:0]}};
			end
			default: begin
				wr_strb = 4'b1111;
				wr_data = req.wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			req.done <= 1'b0;
		end else begin
			req.done <= 1'b0;
			case (state)
				st_idle: if (req.start) begin
					state <= st_addr;
					if (req.store) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
					end else begin
						arvalid <= 1'b1;
					end
				end
				st_addr: if (op_store) begin
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if (!awvalid && !wvalid) begin // both accepted
						bready <= 1'b1;
						state <= st_resp;
					end
				end else if (arready) begin
					arvalid <= 1'b0;
					rready <= 1'b1;
					state <= st_data;
				end
				st_data: if (rvalid) begin
					rready <= 1'b0;
					req.done <= 1'b1;
					state <= st_idle;
				end
				default: if (bvalid) begin
					bready <= 1'b0;
					req.done <= 1'b1;
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && req.start) begin
			op_store <= req.store;
			op_fetch <= req.fetch;
			op_uns <= req.unsigned_ld;
			op_size <= req.size;
			lane <= req.addr[1:0];
			araddr <= {req.addr[xlen-1:2], 2'b00};
			awaddr <= {req.addr[xlen-1:2], 2'b00};
			wdata <= wr_data;
			wstrb <= wr_strb;
		end
		if (state == st_data && rvalid)
			req.rdata <= ld_val;
	end

	a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid && !arready |=> arvalid && $stable(araddr));

	// control must wait for done before the next request
	a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
		req.start |-> state == st_idle);

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_aw = 5;

	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op = 7'b0110011;

	localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra, srai

	localparam logic [xlen-1:0] pc_step = 4;
	localparam logic [xlen-1:0] reset_pc = '0;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt,
		alu_sltu, alu_xor, alu_srl, alu_sra,
		alu_or, alu_and, alu_eq, alu_ne,
		alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_t;

	typedef enum logic [3:0] {
		cls_none, cls_lui, cls_auipc, cls_jal, cls_jalr,
		cls_branch, cls_load, cls_store, cls_alu
	} inst_class_t;

	// encoding matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sz_byte, sz_half, sz_word
	} mem_size_t;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
	input wire logic clk,
	input wire logic rstn,
	decode_if.regfile dec,
	input wire logic we,
	input wire logic [xlen-1:0] wdata,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data
);

	logic [xlen-1:0] regs [2**reg_aw];

	always_ff @(posedge clk) begin
		rs1_data <= regs[dec.rs1]; // x0 holds zero
		rs2_data <= regs[dec.rs2];
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < 2**reg_aw; i++)
				regs[i] <= '0;
		end else if (we && dec.rd != '0) begin
			regs[dec.rd] <= wdata;
		end
	end

	// a writeback with rd of x0 must leave it at zero
	a_x0_kept: assert property (@(posedge clk) disable iff (!rstn)
		we |=> regs[0] == '0);

endmodule

`default_nettype wire

//--- sim.f
rv_pkg.sv
decode_if.sv
lsu_if.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_control.sv
rv_core.sv
tb_rv_core.sv

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

	localparam int prog_len = 200; // program words
	localparam int data_base = 1024; // word index behind x1

	logic clk;
	logic rstn;
	logic arready;
	logic rvalid;
	logic [xlen-1:0] rdata;
	logic awready;
	logic wready;
	logic bvalid;
	wire [xlen-1:0] araddr;
	wire arvalid;
	wire rready;
	wire [xlen-1:0] awaddr;
	wire awvalid;
	wire [xlen-1:0] wdata;
	wire [3:0] wstrb;
	wire wvalid;
	wire bready;

	integer seed;
	logic [xlen-1:0] mem [2048];
	int n_words;

	// instruction-set model
	logic [xlen-1:0] regs [32];
	logic [xlen-1:0] pc, loop_pc, load_addr, store_addr, st_data;
	logic [3:0] st_strb;
	logic load_pend, store_pend, finished;

	// memory responder
	int ar_stall, r_stall, aw_stall, w_stall, b_stall;
	logic ar_wait, aw_wait, aw_got, w_got, r_pend;
	logic [xlen-1:0] ar_addr, aw_addr, got_awaddr, got_wdata, r_addr;
	logic [3:0] got_wstrb;

	rv_core i_dut (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic int rnd(input int k);
		return $unsigned($random(seed)) % k;
	endfunction

	task automatic check_value(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic emit(input logic [xlen-1:0] w);
		mem[n_words] = w;
		n_words = n_words + 1;
	endtask

	task automatic emit_store(input logic [4:0] rs, input logic [2:0] f3);
		logic [11:0] off;
		off = 12'(rnd(2048)); // x1 relative, any alignment
		emit({off[11:5], rs, 5'd1, f3, off[4:0], opc_store});
	endtask

	task automatic emit_alu(input logic [4:0] rd);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] rs1, rs2;
		f3 = 3'(rnd(8));
		f7 = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1) ? funct7_alt : 7'd0;
		rs1 = 5'(rnd(32));
		rs2 = 5'(rnd(32)); // shamt in the shift-immediate form
		if (rnd(2) == 1)
			emit({f7, rs2, rs1, f3, rd, opc_op});
		else if (f3 == 3'd1 || f3 == 3'd5)
			emit({f7, rs2, rs1, f3, rd, opc_op_imm});
		else
			emit({12'(rnd(4096)), rs1, f3, rd, opc_op_imm});
		emit_store(rd, 3'b010);
	endtask

	task automatic build_program();
		logic [4:0] rd;
		logic [2:0] f3;
		int r;
		for (int i = 0; i < 2048; i++)
			mem[i] = (i >= data_base) ? $random(seed) : '0;
		n_words = 0;
		emit({20'h00001, 5'd1, opc_lui}); // x1 = 0x1000
		while (n_words < prog_len - 5) begin
			rd = 5'(2 + rnd(30));
			case (rnd(9))
				0: emit_alu(rd);
				1: begin
					emit({20'($random(seed)), rd, opc_lui});
					emit_store(rd, 3'b010);
				end
				2: begin
					emit({20'($random(seed)), rd, opc_auipc});
					emit_store(rd, 3'b010);
				end
				3: begin
					r = rnd(5);
					f3 = (r < 3) ? 3'(r) : 3'(r + 1); // lb lh lw lbu lhu
					emit({12'(rnd(2048)), 5'd1, f3, rd, opc_load});
					emit_store(rd, 3'b010);
				end
				4: emit_store(5'(rnd(32)), 3'(rnd(3)));
				5: begin
					r = rnd(6);
					f3 = (r < 2) ? 3'(r) : 3'(r + 2);
					// +12 jumps over the alu op and its sw
					emit({7'd0, 5'(rnd(32)), 5'(rnd(32)), f3, 4'b0110, 1'b0, opc_branch});
					emit_alu(rd);
				end
				6: begin
					emit({1'b0, 10'd6, 1'b0, 8'd0, rd, opc_jal});
					emit_alu(rd); // never runs
					emit_store(rd, 3'b010);
				end
				7: begin
					r = 2 + rnd(30);
					emit({20'd0, 5'(r), opc_auipc});
					emit({12'd16, 5'(r), 3'b000, rd, opc_jalr}); // lands on the sw
					emit_alu(rd);
					emit_store(rd, 3'b010);
				end
				default: emit({25'($random(seed)), 7'b1111111}); // unused opcode
			endcase
		end
		loop_pc = n_words * 4;
		emit({20'd0, 5'd0, opc_jal});
	endtask

	function automatic logic [xlen-1:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic set_reg(input logic [4:0] rd, input logic [xlen-1:0] v);
		if (rd != 5'd0)
			regs[rd] = v;
	endtask

	task automatic execute(input logic [xlen-1:0] inst);
		logic [6:0] opc, f7;
		logic [4:0] rd;
		logic [2:0] f3;
		logic alt, take;
		logic [xlen-1:0] a, b, imm_i, ea, v, nxt;
		int nbytes;
		opc = inst[6:0];
		rd = inst[11:7];
		f3 = inst[14:12];
		f7 = inst[31:25];
		alt = f7 == funct7_alt;
		a = regs[inst[19:15]];
		b = regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		ea = a + imm_i;
		nxt = pc + 4;
		case (opc)
			opc_lui: set_reg(rd, {inst[31:12], 12'd0});
			opc_auipc: set_reg(rd, pc + {inst[31:12], 12'd0});
			opc_jal: begin
				set_reg(rd, pc + 4);
				nxt = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			opc_jalr: begin
				nxt = ea & ~32'd1;
				set_reg(rd, pc + 4);
			end
			opc_branch: begin
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					3'd7: take = a >= b;
					default: take = 1'b0;
				endcase
				if (take)
					nxt = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			opc_load: if (f3 != 3'd3 && f3 < 3'd6) begin
				load_pend = 1'b1;
				load_addr = ea;
				v = mem[ea[12:2]];
				if (f3[1:0] == 2'd0) begin
					v = v >> (8 * ea[1:0]);
					v = f3[2] ? {24'd0, v[7:0]} : {{24{v[7]}}, v[7:0]};
				end else if (f3[1:0] == 2'd1) begin
					v = v >> (16 * ea[1]);
					v = f3[2] ? {16'd0, v[15:0]} : {{16{v[15]}}, v[15:0]};
				end
				set_reg(rd, v);
			end
			opc_store: if (f3 < 3'd3) begin
				store_pend = 1'b1;
				store_addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
				nbytes = 1 << f3; // 1, 2 or 4 bytes
				// lane k is written when it sits in the same size-aligned slot as the address
				for (int k = 0; k < 4; k++) begin
					st_strb[k] = (k / nbytes) == (store_addr[1:0] / nbytes);
					st_data[8*k +: 8] = b[8*(k % nbytes) +: 8];
				end
			end
			opc_op_imm: if (f3 == 3'd1 ? f7 == 7'd0 : (f3 != 3'd5 || f7 == 7'd0 || alt))
				set_reg(rd, alu_model(f3, f3 == 3'd5 && alt, a, imm_i));
			opc_op: if (f7 == 7'd0 || (alt && (f3 == 3'd0 || f3 == 3'd5)))
				set_reg(rd, alu_model(f3, alt, a, b));
			default: ; // nop
		endcase
		pc = nxt;
	endtask

	task automatic read_addr_seen(input logic [xlen-1:0] addr);
		if (load_pend) begin
			check_value("araddr", addr, {load_addr[xlen-1:2], 2'b00});
			load_pend = 1'b0;
		end else begin
			check_value("araddr", addr, pc); // fetch
			check_value("store outstanding", store_pend, 1'b0);
			if (pc == loop_pc)
				finished = 1'b1;
			else
				execute(mem[pc[12:2]]);
		end
	endtask

	task automatic write_seen(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
		input logic [3:0] strb);
		logic [xlen-1:0] mask;
		check_value("store expected", store_pend, 1'b1);
		check_value("awaddr", addr, {store_addr[xlen-1:2], 2'b00});
		check_value("wstrb", strb, st_strb);
		mask = {{8{st_strb[3]}}, {8{st_strb[2]}}, {8{st_strb[1]}}, {8{st_strb[0]}}};
		check_value("wdata", data & mask, st_data & mask);
		mem[addr[12:2]] = (mem[addr[12:2]] & ~mask) | (st_data & mask);
		store_pend = 1'b0;
	endtask

	always @(negedge clk) begin
		if (rstn) begin
			arready = 1'b0;
			rvalid = 1'b0;
			awready = 1'b0;
			wready = 1'b0;
			bvalid = 1'b0;
			if (r_pend && rready) begin
				if (r_stall == 0) begin
					rvalid = 1'b1;
					rdata = mem[r_addr[12:2]];
					r_pend = 1'b0;
					r_stall = rnd(4);
				end else begin
					r_stall = r_stall - 1;
				end
			end
			if (ar_wait) begin // stalled last cycle
				check_value("arvalid", arvalid, 1'b1);
				check_value("araddr", araddr, ar_addr);
			end
			ar_wait = 1'b0;
			if (arvalid) begin
				if (ar_stall == 0) begin
					arready = 1'b1;
					ar_stall = rnd(4);
					r_pend = 1'b1;
					r_addr = araddr;
					read_addr_seen(araddr);
				end else begin
					ar_stall = ar_stall - 1;
					ar_wait = 1'b1;
					ar_addr = araddr;
				end
			end
			if (aw_wait) begin
				check_value("awvalid", awvalid, 1'b1);
				check_value("awaddr", awaddr, aw_addr);
			end
			aw_wait = 1'b0;
			if (awvalid && !aw_got) begin
				if (aw_stall == 0) begin
					awready = 1'b1;
					aw_stall = rnd(4);
					aw_got = 1'b1;
					got_awaddr = awaddr;
				end else begin
					aw_stall = aw_stall - 1;
					aw_wait = 1'b1;
					aw_addr = awaddr;
				end
			end
			if (wvalid && !w_got) begin
				if (w_stall == 0) begin
					wready = 1'b1;
					w_stall = rnd(4);
					w_got = 1'b1;
					got_wdata = wdata;
					got_wstrb = wstrb;
				end else begin
					w_stall = w_stall - 1;
				end
			end
			if (bready) begin
				if (b_stall == 0) begin
					bvalid = 1'b1;
					b_stall = rnd(4);
					write_seen(got_awaddr, got_wdata, got_wstrb);
					aw_got = 1'b0;
					w_got = 1'b0;
				end else begin
					b_stall = b_stall - 1;
				end
			end
		end
	end

	initial begin
		seed = 74113;
		rstn = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		pc = reset_pc;
		load_pend = 1'b0;
		store_pend = 1'b0;
		finished = 1'b0;
		ar_wait = 1'b0;
		aw_wait = 1'b0;
		aw_got = 1'b0;
		w_got = 1'b0;
		r_pend = 1'b0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		ar_stall = rnd(4);
		r_stall = rnd(4);
		aw_stall = rnd(4);
		w_stall = rnd(4);
		b_stall = rnd(4);
		build_program();
		repeat (2) @(negedge clk);
		check_value("arvalid", arvalid, 1'b0);
		check_value("rready", rready, 1'b0);
		check_value("awvalid", awvalid, 1'b0);
		check_value("wvalid", wvalid, 1'b0);
		check_value("bready", bready, 1'b0);
		rstn = 1'b1;
		wait (finished);
		@(negedge clk);
		$display("PASS: all tests");
		$finish;
	end

	// generous per-instruction budget
	initial begin
		#(prog_len * 40 * 20);
		$display("timeout: the core did not reach the final loop of the program");
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
